/* rtl/memproc_defines.svh */
`ifndef MEMPROC_DEFINES_SVH
`define MEMPROC_DEFINES_SVH

// datapath widths
`define MP_DATA_W 16  // memory word / command data
`define MP_ADDR_W 6  // word address, 64 words

// flow control
// host command credits; the response queue has the same depth, so it can never
// hold more entries than there are commands in flight
`define MP_CREDITS 4

// ram options
`define MP_RAM_MODE "RAW"  // same-port read during write returns new data

`endif

/* rtl/memproc_pkg.sv */
package memproc_pkg;

	// command opcodes, encoding matches the raw two-bit cmd_op_i field
	typedef enum logic [1:0] {
		OP_RD  = 2'd0,  // read, word unchanged
		OP_WR  = 2'd1,  // overwrite with cmd data
		OP_ADD = 2'd2,  // mem += cmd data, wraps
		OP_XOR = 2'd3  // mem ^= cmd data
	} mp_op_e;

endpackage

/* rtl/dp_ram_infer.sv */
`timescale 1ns/100ps

module dp_ram_infer #(
	parameter integer REG_A_OUT = 1,  // 1 = extra output reg on port a
	parameter integer REG_B_OUT = 1,  // 1 = extra output reg on port b
	parameter integer DATA_W    = 16,
	parameter integer ADDR_W    = 8,
	parameter         MODE      = "RAW"  // "RAW" new data, "WAR" old data
) (
	input  logic              a_clk_i,  // shared by both ports
	input  logic [ADDR_W-1:0] a_addr_i,
	input  logic              a_wr_i,  // active high
	input  logic [DATA_W-1:0] a_data_i,
	output logic [DATA_W-1:0] a_data_o,
	input  logic [ADDR_W-1:0] b_addr_i,
	input  logic              b_wr_i,  // active high
	input  logic [DATA_W-1:0] b_data_i,
	output logic [DATA_W-1:0] b_data_o
);

	localparam integer CAPACITY = 2**ADDR_W;  // words
	localparam bit     RAW_MODE = (MODE == "RAW");  // same-port bypass on write

	logic [DATA_W-1:0] ram [CAPACITY];  // storage
	logic [DATA_W-1:0] a_data;  // port a read reg
	logic [DATA_W-1:0] b_data;  // port b read reg

	initial begin
		for (int i = 0; i < CAPACITY; i++) begin
			ram[i] = '0;  // power-up contents
		end
	end

	// writes, port b wins an address collision
	always @(posedge a_clk_i) begin
		if (a_wr_i) begin
			ram[a_addr_i] <= a_data_i;
		end
		if (b_wr_i) begin
			ram[b_addr_i] <= b_data_i;
		end
	end

	// synchronous reads, one clock after the address
	always_ff @(posedge a_clk_i) begin
		a_data <= (a_wr_i && RAW_MODE) ? a_data_i : ram[a_addr_i];
		b_data <= (b_wr_i && RAW_MODE) ? b_data_i : ram[b_addr_i];
	end

	// optional output stage, one more clock
	if (REG_A_OUT != 0) begin : g_a_reg
		logic [DATA_W-1:0] a_data_r;
		always_ff @(posedge a_clk_i) begin
			a_data_r <= a_data;
		end
		assign a_data_o = a_data_r;
	end else begin : g_a_direct
		assign a_data_o = a_data;
	end

	if (REG_B_OUT != 0) begin : g_b_reg
		logic [DATA_W-1:0] b_data_r;
		always_ff @(posedge a_clk_i) begin
			b_data_r <= b_data;
		end
		assign b_data_o = b_data_r;
	end else begin : g_b_direct
		assign b_data_o = b_data;
	end

endmodule

/* rtl/mp_decode.sv */
`timescale 1ns/100ps
`include "memproc_defines.svh"

module mp_decode (
	input  logic                        a_clk_i,
	input  logic                        rst_n_i,  // async, active low
	// host command
	input  logic                        cmd_valid_i,  // one cycle per command
	input  logic [1:0]                  cmd_op_i,  // raw opcode bits
	input  logic [`MP_ADDR_W-1:0]       cmd_addr_i,
	input  logic [`MP_DATA_W-1:0]       cmd_data_i,
	// ram port a read address
	output logic [`MP_ADDR_W-1:0]       ram_addr_o,
	// to execute
	output logic                        dec_valid_o,
	output memproc_pkg::mp_op_e         dec_op_o,
	output logic [`MP_ADDR_W-1:0]       dec_addr_o,
	output logic [`MP_DATA_W-1:0]       dec_data_o
);

	memproc_pkg::mp_op_e cmd_op;  // decoded opcode

	assign cmd_op = memproc_pkg::mp_op_e'(cmd_op_i);  // bits map 1:1 onto the enum

	// read starts in the accept cycle, data lands with the decode reg
	assign ram_addr_o = cmd_addr_i;

	// valid bit
	always_ff @(posedge a_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			dec_valid_o <= 1'b0;
		end else begin
			dec_valid_o <= cmd_valid_i;  // no stall, every command moves on
		end
	end

	// command payload, only loads on accept
	always_ff @(posedge a_clk_i) begin
		if (cmd_valid_i) begin
			dec_op_o   <= cmd_op;
			dec_addr_o <= cmd_addr_i;
			dec_data_o <= cmd_data_i;
		end
	end

endmodule

/* rtl/mp_execute.sv */
`timescale 1ns/100ps
`include "memproc_defines.svh"

module mp_execute (
	input  logic                        a_clk_i,
	input  logic                        rst_n_i,  // async, active low
	// from decode
	input  logic                        dec_valid_i,
	input  memproc_pkg::mp_op_e         dec_op_i,
	input  logic [`MP_ADDR_W-1:0]       dec_addr_i,
	input  logic [`MP_DATA_W-1:0]       dec_data_i,
	input  logic [`MP_DATA_W-1:0]       ram_rdata_i,  // port a data, same cycle as dec_*
	// word written last cycle, missed by the ram read
	input  logic                        fwd_valid_i,
	input  logic [`MP_ADDR_W-1:0]       fwd_addr_i,
	input  logic [`MP_DATA_W-1:0]       fwd_word_i,
	// to result
	output logic                        exe_valid_o,
	output logic [`MP_ADDR_W-1:0]       exe_addr_o,
	output logic [`MP_DATA_W-1:0]       exe_word_o
);

	logic                  hit_own;  // previous command, same address
	logic                  hit_fwd;  // command two back, same address
	logic [`MP_DATA_W-1:0] operand;  // newest memory value
	logic [`MP_DATA_W-1:0] new_word;

	assign hit_own = exe_valid_o && (exe_addr_o == dec_addr_i);
	assign hit_fwd = fwd_valid_i && (fwd_addr_i == dec_addr_i);

	// newest first: own reg, then result stage, then ram
	always_comb begin
		if (hit_own) begin
			operand = exe_word_o;
		end else if (hit_fwd) begin
			operand = fwd_word_i;
		end else begin
			operand = ram_rdata_i;
		end
	end

	// opcode alu
	always_comb begin
		new_word = operand;  // OP_RD writes back unchanged
		unique case (dec_op_i)
			memproc_pkg::OP_RD:  new_word = operand;
			memproc_pkg::OP_WR:  new_word = dec_data_i;
			memproc_pkg::OP_ADD: new_word = operand + dec_data_i;  // wraps at data width
			memproc_pkg::OP_XOR: new_word = operand ^ dec_data_i;
			default:             new_word = operand;
		endcase
	end

	always_ff @(posedge a_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			exe_valid_o <= 1'b0;
		end else begin
			exe_valid_o <= dec_valid_i;
		end
	end

	// payload, held while idle so the forward compare stays stable
	always_ff @(posedge a_clk_i) begin
		if (dec_valid_i) begin
			exe_addr_o <= dec_addr_i;
			exe_word_o <= new_word;
		end
	end

endmodule

/* rtl/mp_result.sv */
`timescale 1ns/100ps
`include "memproc_defines.svh"

module mp_result (
	input  logic                        a_clk_i,
	input  logic                        rst_n_i,  // async, active low
	// from execute
	input  logic                        exe_valid_i,
	input  logic [`MP_ADDR_W-1:0]       exe_addr_i,
	input  logic [`MP_DATA_W-1:0]       exe_word_i,
	// ram port b write
	output logic [`MP_ADDR_W-1:0]       ram_waddr_o,
	output logic                        ram_wr_o,
	output logic [`MP_DATA_W-1:0]       ram_wdata_o,
	// last written word back to execute
	output logic                        fwd_valid_o,
	output logic [`MP_ADDR_W-1:0]       fwd_addr_o,
	output logic [`MP_DATA_W-1:0]       fwd_word_o,
	// response side
	input  logic                        rsp_credit_i,  // one pulse per consumer credit
	output logic                        rsp_valid_o,
	output logic [`MP_DATA_W-1:0]       rsp_data_o,
	output logic                        cmd_credit_o  // back to host
);

	localparam integer PTR_W = (`MP_CREDITS > 1) ? $clog2(`MP_CREDITS) : 1;
	localparam integer CNT_W = $clog2(`MP_CREDITS + 1);
	localparam integer CRD_W = 8;  // headroom for early consumer credits

	logic [`MP_DATA_W-1:0] q_mem [`MP_CREDITS];  // response queue
	logic [PTR_W-1:0]      wr_ptr;
	logic [PTR_W-1:0]      rd_ptr;
	logic [CNT_W-1:0]      q_cnt;  // entries held
	logic [CRD_W-1:0]      crd_cnt;  // response credits held
	logic                  push;
	logic                  pop;

	// every valid word goes to memory, reads included
	assign ram_wr_o    = exe_valid_i;
	assign ram_waddr_o = exe_addr_i;
	assign ram_wdata_o = exe_word_i;

	assign push = exe_valid_i;
	assign pop  = (crd_cnt != '0) && (q_cnt != '0);  // credit and entry both present

	assign rsp_valid_o  = pop;
	assign rsp_data_o   = q_mem[rd_ptr];
	assign cmd_credit_o = pop;  // one host credit per response sent

	// a read issued alongside this write sees old data, so keep a copy one cycle
	always_ff @(posedge a_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			fwd_valid_o <= 1'b0;
		end else begin
			fwd_valid_o <= exe_valid_i;
		end
	end

	always_ff @(posedge a_clk_i) begin
		if (exe_valid_i) begin
			fwd_addr_o <= exe_addr_i;
			fwd_word_o <= exe_word_i;
		end
	end

	// queue storage
	always_ff @(posedge a_clk_i) begin
		if (push) begin
			q_mem[wr_ptr] <= exe_word_i;
		end
	end

	// pointers, counts and credits
	always_ff @(posedge a_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			q_cnt   <= '0;
			crd_cnt <= '0;  // consumer grants its first credits after reset
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(`MP_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;  // wrap
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(`MP_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
			end
			q_cnt   <= q_cnt + CNT_W'(push) - CNT_W'(pop);
			crd_cnt <= crd_cnt + CRD_W'(rsp_credit_i) - CRD_W'(pop);
		end
	end

endmodule

/* rtl/memproc_top.sv */
`timescale 1ns/100ps
`include "memproc_defines.svh"

module memproc_top (
	input  logic                  a_clk_i,
	input  logic                  rst_n_i,  // async, active low
	// command side
	input  logic                  cmd_valid_i,
	input  logic [1:0]            cmd_op_i,
	input  logic [`MP_ADDR_W-1:0] cmd_addr_i,
	input  logic [`MP_DATA_W-1:0] cmd_data_i,
	output logic                  cmd_credit_o,
	// response side
	input  logic                  rsp_credit_i,
	output logic                  rsp_valid_o,
	output logic [`MP_DATA_W-1:0] rsp_data_o
);

	logic [`MP_ADDR_W-1:0] ram_raddr;  // port a
	logic [`MP_DATA_W-1:0] ram_rdata;
	logic [`MP_ADDR_W-1:0] ram_waddr;  // port b
	logic                  ram_wr;
	logic [`MP_DATA_W-1:0] ram_wdata;
	logic                  dec_valid;  // decode -> execute
	memproc_pkg::mp_op_e   dec_op;
	logic [`MP_ADDR_W-1:0] dec_addr;
	logic [`MP_DATA_W-1:0] dec_data;
	logic                  exe_valid;  // execute -> result
	logic [`MP_ADDR_W-1:0] exe_addr;
	logic [`MP_DATA_W-1:0] exe_word;
	logic                  fwd_valid;  // result -> execute
	logic [`MP_ADDR_W-1:0] fwd_addr;
	logic [`MP_DATA_W-1:0] fwd_word;

	mp_decode u_decode (
		.a_clk_i(a_clk_i), .rst_n_i(rst_n_i),
		.cmd_valid_i(cmd_valid_i), .cmd_op_i(cmd_op_i),
		.cmd_addr_i(cmd_addr_i), .cmd_data_i(cmd_data_i),
		.ram_addr_o(ram_raddr),
		.dec_valid_o(dec_valid), .dec_op_o(dec_op),
		.dec_addr_o(dec_addr), .dec_data_o(dec_data)
	);

	// port a reads only, port b writes only
	dp_ram_infer #(
		.REG_A_OUT(0), .REG_B_OUT(0),
		.DATA_W(`MP_DATA_W), .ADDR_W(`MP_ADDR_W), .MODE(`MP_RAM_MODE)
	) u_ram (
		.a_clk_i(a_clk_i),
		.a_addr_i(ram_raddr), .a_wr_i(1'b0), .a_data_i('0), .a_data_o(ram_rdata),
		.b_addr_i(ram_waddr), .b_wr_i(ram_wr), .b_data_i(ram_wdata), .b_data_o()
	);

	mp_execute u_execute (
		.a_clk_i(a_clk_i), .rst_n_i(rst_n_i),
		.dec_valid_i(dec_valid), .dec_op_i(dec_op),
		.dec_addr_i(dec_addr), .dec_data_i(dec_data),
		.ram_rdata_i(ram_rdata),
		.fwd_valid_i(fwd_valid), .fwd_addr_i(fwd_addr), .fwd_word_i(fwd_word),
		.exe_valid_o(exe_valid), .exe_addr_o(exe_addr), .exe_word_o(exe_word)
	);

	mp_result u_result (
		.a_clk_i(a_clk_i), .rst_n_i(rst_n_i),
		.exe_valid_i(exe_valid), .exe_addr_i(exe_addr), .exe_word_i(exe_word),
		.ram_waddr_o(ram_waddr), .ram_wr_o(ram_wr), .ram_wdata_o(ram_wdata),
		.fwd_valid_o(fwd_valid), .fwd_addr_o(fwd_addr), .fwd_word_o(fwd_word),
		.rsp_credit_i(rsp_credit_i), .rsp_valid_o(rsp_valid_o),
		.rsp_data_o(rsp_data_o), .cmd_credit_o(cmd_credit_o)
	);

endmodule

/* verif/memproc_tb.sv */
`timescale 1ns/100ps
`include "memproc_defines.svh"

module memproc_tb;

	localparam int TB_RSP_CREDITS = 2;  // consumer grants these right after reset
	localparam int RND_CMDS       = 300;
	localparam int TOTAL_CMDS     = 8 + 16 + 12 + RND_CMDS;
	localparam int TIMEOUT_CYCLES = 20 * TOTAL_CMDS + 200;
	localparam int DEPTH          = 2**`MP_ADDR_W;

	logic                  a_clk_i;
	logic                  rst_n_i;
	logic                  cmd_valid_i;
	logic [1:0]            cmd_op_i;
	logic [`MP_ADDR_W-1:0] cmd_addr_i;
	logic [`MP_DATA_W-1:0] cmd_data_i;
	logic                  cmd_credit_o;
	logic                  rsp_credit_i;
	logic                  rsp_valid_o;
	logic [`MP_DATA_W-1:0] rsp_data_o;

	logic [`MP_DATA_W-1:0] model_mem [DEPTH];  // reference memory
	logic [`MP_DATA_W-1:0] exp_q [$];  // expected responses in command order
	int                    host_credits;  // command credits held by the host
	int                    rsp_avail;  // response credits the DUT should hold
	int                    cycle_cnt;
	int                    err_cnt;
	int                    chk_cnt;
	int                    cmd_cnt;  // commands sent in the current test
	int                    err_start;
	bit                    crd_always;  // consumer grants whenever it has room

	memproc_top dut_i (
		.a_clk_i(a_clk_i), .rst_n_i(rst_n_i),
		.cmd_valid_i(cmd_valid_i), .cmd_op_i(cmd_op_i),
		.cmd_addr_i(cmd_addr_i), .cmd_data_i(cmd_data_i),
		.cmd_credit_o(cmd_credit_o),
		.rsp_credit_i(rsp_credit_i), .rsp_valid_o(rsp_valid_o),
		.rsp_data_o(rsp_data_o)
	);

	initial begin
		a_clk_i = 1'b0;
		forever #10 a_clk_i = ~a_clk_i;  // 20 ns period
	end

	function automatic logic [31:0] rand_next(input logic [31:0] state);
		logic [31:0] s;
		s = state ^ (state << 13);  // xorshift32
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// applies one command to the model memory and returns the response word
	function automatic logic [`MP_DATA_W-1:0] ref_apply(input memproc_pkg::mp_op_e op,
		input logic [`MP_ADDR_W-1:0] addr, input logic [`MP_DATA_W-1:0] data);
		logic [`MP_DATA_W-1:0] word;
		word = model_mem[addr];
		case (op)
			memproc_pkg::OP_WR:  word = data;
			memproc_pkg::OP_ADD: word = word + data;  // wraps at data width
			memproc_pkg::OP_XOR: word = word ^ data;
			default:             word = word;  // read leaves memory as is
		endcase
		model_mem[addr] = word;
		return word;
	endfunction

	task automatic check_value(input logic [`MP_DATA_W-1:0] got,
		input logic [`MP_DATA_W-1:0] exp, input string msg);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("Fail %0t: %s got %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic flag_error(input string msg);
		err_cnt++;
		$display("at %0t: %s", $time, msg);
	endtask

	// entered and left 2 ns after a rising edge
	task automatic send_cmd(input memproc_pkg::mp_op_e op,
		input logic [`MP_ADDR_W-1:0] addr, input logic [`MP_DATA_W-1:0] data);
		while (host_credits == 0) begin  // hold off until a credit returns
			@(posedge a_clk_i);
			#2;
		end
		cmd_valid_i = 1'b1;
		cmd_op_i    = op;
		cmd_addr_i  = addr;
		cmd_data_i  = data;
		host_credits--;
		cmd_cnt++;
		exp_q.push_back(ref_apply(op, addr, data));
		@(posedge a_clk_i);
		#2;
		cmd_valid_i = 1'b0;
	endtask

	task automatic drain();
		while (exp_q.size() != 0 || host_credits != `MP_CREDITS) begin
			@(posedge a_clk_i);
			#2;
		end
	endtask

	task automatic report_test(input int num, input string name);
		$display("test %0d %s: %0d commands, %0d errors", num, name, cmd_cnt,
			err_cnt - err_start);
		cmd_cnt   = 0;
		err_start = err_cnt;
	endtask

	// compare process samples mid-cycle where outputs are settled
	always @(negedge a_clk_i) begin
		if (!rst_n_i) begin
			if (cycle_cnt > 0 && (rsp_valid_o !== 1'b0 || cmd_credit_o !== 1'b0)) begin
				flag_error("response or credit output not low during reset");
			end
		end else begin
			if (cmd_credit_o !== rsp_valid_o) begin
				flag_error("command credit pulse does not match a response");
			end
			if (rsp_valid_o) begin
				if (rsp_avail == 0) begin
					flag_error("response sent without a response credit");
				end else begin
					rsp_avail--;
				end
				if (exp_q.size() == 0) begin
					flag_error("response arrived with no command outstanding");
				end else begin
					check_value(rsp_data_o, exp_q.pop_front(), "response data");
				end
			end
			if (cmd_credit_o) begin
				host_credits++;
				if (host_credits > `MP_CREDITS) begin
					flag_error("command credit overflow at the host");
				end
			end
			if (host_credits + exp_q.size() != `MP_CREDITS) begin
				flag_error("outstanding commands and host credits out of balance");
			end
			if (rsp_credit_i) begin
				rsp_avail++;  // counted by the DUT from the next cycle
			end
		end
	end

	// consumer gives an initial grant then random returns capped by its buffer room
	initial begin
		logic [31:0] crd_rnd;  // own random stream
		crd_rnd = 32'hb072dbcd;
		wait (rst_n_i === 1'b1);
		repeat (TB_RSP_CREDITS) begin
			@(posedge a_clk_i);
			#2;
			rsp_credit_i = 1'b1;
		end
		forever begin
			@(posedge a_clk_i);
			#2;
			crd_rnd      = rand_next(crd_rnd);
			rsp_credit_i = (rsp_avail < `MP_CREDITS) && (crd_always || crd_rnd[0]);
		end
	end

	// watchdog
	always @(posedge a_clk_i) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("run stopped, no progress within %0d cycles", TIMEOUT_CYCLES);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	initial begin
		logic [31:0]         r;
		memproc_pkg::mp_op_e op;
		rst_n_i      = 1'b0;
		cmd_valid_i  = 1'b0;
		cmd_op_i     = 2'd0;
		cmd_addr_i   = '0;
		cmd_data_i   = '0;
		rsp_credit_i = 1'b0;
		host_credits = `MP_CREDITS;
		rsp_avail    = 0;
		crd_always   = 1'b1;
		r            = 32'hb072dbcd;  // host random stream
		for (int i = 0; i < DEPTH; i++) begin
			model_mem[i] = '0;  // RAM powers up cleared
		end
		repeat (5) @(posedge a_clk_i);
		#2;
		rst_n_i = 1'b1;

		// reads right after reset
		for (int i = 0; i < 8; i++) begin
			send_cmd(memproc_pkg::OP_RD, `MP_ADDR_W'(i * 9), '0);  // spread over the RAM
		end
		drain();
		report_test(1, "reads after reset");

		// writes echo data and reads return it
		for (int i = 0; i < 8; i++) begin
			r = rand_next(r);
			send_cmd(memproc_pkg::OP_WR, `MP_ADDR_W'(i * 7 + 3), r[`MP_DATA_W-1:0]);
		end
		for (int i = 0; i < 8; i++) begin
			send_cmd(memproc_pkg::OP_RD, `MP_ADDR_W'(i * 7 + 3), '0);
		end
		drain();
		report_test(2, "write then read");

		// same address back to back with two gaps that reach the result stage and the ram
		send_cmd(memproc_pkg::OP_WR, `MP_ADDR_W'(9), 16'h1234);
		for (int i = 0; i < 10; i++) begin
			r = rand_next(r);
			op = i[0] ? memproc_pkg::OP_XOR : memproc_pkg::OP_ADD;
			repeat ((i == 4) ? 1 : (i == 7) ? 2 : 0) begin  // idle cycles
				@(posedge a_clk_i);
				#2;
			end
			send_cmd(op, `MP_ADDR_W'(9), r[`MP_DATA_W-1:0]);
		end
		send_cmd(memproc_pkg::OP_RD, `MP_ADDR_W'(9), '0);
		drain();
		report_test(3, "back-to-back accumulate");

		// random traffic over eight addresses with random credit return
		crd_always = 1'b0;
		for (int i = 0; i < RND_CMDS; i++) begin
			r = rand_next(r);
			if (r[31:30] == 2'b00) begin
				@(posedge a_clk_i);  // idle cycle now and then
				#2;
			end
			op = memproc_pkg::mp_op_e'(r[1:0]);
			send_cmd(op, `MP_ADDR_W'(r[4:2]), r[23:8]);
		end
		drain();
		report_test(4, "random commands");

		$display("%0d checks, %0d errors", chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

/* memproc.f */
+incdir+rtl
rtl/memproc_pkg.sv
rtl/dp_ram_infer.sv
rtl/mp_decode.sv
rtl/mp_execute.sv
rtl/mp_result.sv
rtl/memproc_top.sv
verif/memproc_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the memproc testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f memproc.f --top-module memproc_tb -o memproc_sim

./obj_dir/memproc_sim | tee sim.log

if grep -q "^NO ERRORS$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
